/* design/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// core word and line geometry
`define WORD_BITS   32
`define LINE_BYTES  16
`define LINE_BITS   128

// backing store depth in lines, 1 KiB total
`define MEM_LINES   64

// direct-mapped cache entries
`define CACHE_LINES 8

// cycles from a memory strobe to its done pulse
`define MEM_LATENCY 6

`endif

/* design/mem_access_pkg.sv */
`include "mem_params.svh"

package mem_access_pkg;

    // access width as encoded by the core
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // one core data word
    typedef logic [`WORD_BITS-1:0] word_t;

    // one enable per byte lane of a word
    typedef logic [`WORD_BITS/8-1:0] byte_mask_t;

endpackage

/* design/mem_ctrl_pkg.sv */
`include "mem_params.svh"

package mem_ctrl_pkg;

    // controller sequencing
    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_LOOKUP = 2'd1,
        ST_FILL   = 2'd2,
        ST_WRITE  = 2'd3
    } ctrl_state_e;

    // one full cache/memory line
    typedef logic [`LINE_BITS-1:0] line_t;

    // byte address with the in-line offset dropped
    typedef logic [`WORD_BITS-$clog2(`LINE_BYTES)-1:0] line_addr_t;

endpackage

/* design/line_cache.sv */
`include "mem_params.svh"

module line_cache (
    input  logic                     CLK,
    input  logic                     i_rrst_x,
    input  mem_ctrl_pkg::line_addr_t i_addr,
    input  logic                     i_fill,
    input  mem_ctrl_pkg::line_t      i_fill_line,
    input  logic                     i_inval,
    output mem_ctrl_pkg::line_t      o_line,
    output logic                     o_hit
);

    localparam int IDX_BITS = $clog2(`CACHE_LINES);
    localparam int TAG_BITS = $bits(mem_ctrl_pkg::line_addr_t) - IDX_BITS;

    logic [IDX_BITS-1:0]     w_idx;
    logic [TAG_BITS-1:0]     w_tag;
    logic [`CACHE_LINES-1:0] r_valid;
    logic [TAG_BITS-1:0]     mem_tag [`CACHE_LINES];
    mem_ctrl_pkg::line_t     mem_data [`CACHE_LINES];
    logic                    r_valid_q;
    logic [TAG_BITS-1:0]     r_tag_q;
    logic [TAG_BITS-1:0]     r_tag_cmp;

    assign {w_tag, w_idx} = i_addr;

    // valid bits, fill sets and invalidate clears
    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_valid   <= '0;
            r_valid_q <= 1'b0;
        end else begin
            if (i_fill) begin
                r_valid[w_idx] <= 1'b1;
            end else if (i_inval) begin
                r_valid[w_idx] <= 1'b0;
            end
            r_valid_q <= r_valid[w_idx];
        end
    end

    // tag and data arrays, read one cycle after the address
    always_ff @(posedge CLK) begin
        if (i_fill) begin
            mem_tag[w_idx]  <= w_tag;
            mem_data[w_idx] <= i_fill_line;
        end
        r_tag_q   <= mem_tag[w_idx];
        o_line    <= mem_data[w_idx];
        r_tag_cmp <= w_tag;
    end

    assign o_hit = r_valid_q && (r_tag_q == r_tag_cmp);

endmodule

/* design/backing_mem.sv */
`include "mem_params.svh"

module backing_mem (
    input  logic                       CLK,
    input  logic                       i_rrst_x,
    input  logic                       i_rd,
    input  logic                       i_wr,
    input  mem_access_pkg::word_t      i_addr,
    input  mem_access_pkg::word_t      i_wdata,
    input  mem_access_pkg::byte_mask_t i_mask,
    output mem_ctrl_pkg::line_t        o_line,
    output logic                       o_done
);

    localparam int IDX_BITS = $clog2(`MEM_LINES);
    localparam int CNT_BITS = $clog2(`MEM_LATENCY + 1);

    // starts out all zero like a cleared DRAM
    mem_ctrl_pkg::line_t        mem [`MEM_LINES] = '{default: '0};
    logic [CNT_BITS-1:0]        r_cnt;
    logic                       r_wr;
    mem_access_pkg::word_t      r_addr;
    mem_access_pkg::word_t      r_wdata;
    mem_access_pkg::byte_mask_t r_mask;
    logic                       w_start;
    logic                       w_fire;
    logic [IDX_BITS-1:0]        w_idx;
    logic [`LINE_BYTES-1:0]     w_be;
    mem_ctrl_pkg::line_t        w_wline;

    // strobes are dropped while a countdown runs
    assign w_start = (i_rd || i_wr) && (r_cnt == '0);
    // last counting cycle, done follows on the next edge
    assign w_fire  = (r_cnt == CNT_BITS'(1));

    // upper address bits ignored, addresses wrap
    assign w_idx   = r_addr[4 +: IDX_BITS];
    assign w_be    = `LINE_BYTES'(r_mask) << {r_addr[3:2], 2'b00};
    assign w_wline = {4{r_wdata}};

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_cnt  <= '0;
            o_done <= 1'b0;
        end else begin
            o_done <= w_fire;
            if (w_start) begin
                r_cnt <= CNT_BITS'(`MEM_LATENCY - 1);
            end else if (r_cnt != '0) begin
                r_cnt <= r_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (w_start) begin
            r_wr    <= i_wr;
            r_addr  <= i_addr;
            r_wdata <= i_wdata;
            r_mask  <= i_mask;
        end
        if (w_fire && !r_wr) begin
            o_line <= mem[w_idx];
        end
    end

    // masked byte writes into the addressed word
    always_ff @(posedge CLK) begin
        if (w_fire && r_wr) begin
            for (int i = 0; i < `LINE_BYTES; i++) begin
                if (w_be[i]) begin
                    mem[w_idx][i*8 +: 8] <= w_wline[i*8 +: 8];
                end
            end
        end
    end

endmodule

/* design/cache_ctrl.sv */
module cache_ctrl (
    input  logic                       CLK,
    input  logic                       i_rrst_x,
    input  logic                       i_req_rd,
    input  logic                       i_req_wr,
    input  mem_access_pkg::word_t      i_req_addr,
    input  mem_access_pkg::word_t      i_req_wdata,
    input  mem_access_pkg::byte_mask_t i_req_mask,
    output mem_ctrl_pkg::line_t        o_line,
    output logic                       o_busy
);

    mem_ctrl_pkg::ctrl_state_e r_state;
    mem_ctrl_pkg::line_addr_t  r_addr;
    mem_ctrl_pkg::line_addr_t  w_cache_addr;
    mem_ctrl_pkg::line_t       w_cache_line;
    mem_ctrl_pkg::line_t       w_mem_line;
    mem_access_pkg::word_t     w_mem_addr;
    logic                      w_idle;
    logic                      w_hit;
    logic                      w_fill;
    logic                      w_inval;
    logic                      w_mem_rd;
    logic                      w_mem_wr;
    logic                      w_mem_done;

    assign w_idle = (r_state == mem_ctrl_pkg::ST_IDLE);
    assign o_busy = !w_idle;

    // new requests go straight to the cache and memory while idle
    assign w_cache_addr = w_idle ? i_req_addr[31:4] : r_addr;
    assign w_mem_addr   = w_idle ? i_req_addr : {r_addr, 4'd0};

    assign w_mem_wr = w_idle && i_req_wr;
    assign w_mem_rd = (r_state == mem_ctrl_pkg::ST_LOOKUP) && !w_hit;
    assign w_fill   = (r_state == mem_ctrl_pkg::ST_FILL) && w_mem_done;
    // stale copy must go once memory holds the new bytes
    assign w_inval  = (r_state == mem_ctrl_pkg::ST_WRITE) && w_hit;

    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            r_state <= mem_ctrl_pkg::ST_IDLE;
        end else begin
            case (r_state)
                mem_ctrl_pkg::ST_IDLE: begin
                    if (i_req_wr) begin
                        r_state <= mem_ctrl_pkg::ST_WRITE;
                    end else if (i_req_rd) begin
                        r_state <= mem_ctrl_pkg::ST_LOOKUP;
                    end
                end
                mem_ctrl_pkg::ST_LOOKUP: begin
                    r_state <= w_hit ? mem_ctrl_pkg::ST_IDLE : mem_ctrl_pkg::ST_FILL;
                end
                mem_ctrl_pkg::ST_FILL,
                mem_ctrl_pkg::ST_WRITE: begin
                    if (w_mem_done) begin
                        r_state <= mem_ctrl_pkg::ST_IDLE;
                    end
                end
                default: r_state <= mem_ctrl_pkg::ST_IDLE;
            endcase
        end
    end

    // request line and result line
    always_ff @(posedge CLK) begin
        if (w_idle && (i_req_rd || i_req_wr)) begin
            r_addr <= i_req_addr[31:4];
        end
        if ((r_state == mem_ctrl_pkg::ST_LOOKUP) && w_hit) begin
            o_line <= w_cache_line;
        end else if (w_fill) begin
            o_line <= w_mem_line;
        end
    end

    line_cache u_cache (
        .CLK         (CLK),
        .i_rrst_x    (i_rrst_x),
        .i_addr      (w_cache_addr),
        .i_fill      (w_fill),
        .i_fill_line (w_mem_line),
        .i_inval     (w_inval),
        .o_line      (w_cache_line),
        .o_hit       (w_hit)
    );

    backing_mem u_mem (
        .CLK      (CLK),
        .i_rrst_x (i_rrst_x),
        .i_rd     (w_mem_rd),
        .i_wr     (w_mem_wr),
        .i_addr   (w_mem_addr),
        .i_wdata  (i_req_wdata),
        .i_mask   (i_req_mask),
        .o_line   (w_mem_line),
        .o_done   (w_mem_done)
    );

endmodule

/* design/mem_access_unit.sv */
module mem_access_unit (
    input  logic                         CLK,
    input  logic                         i_rrst_x,
    input  logic                         i_rd_en,
    input  logic                         i_wr_en,
    input  mem_access_pkg::word_t        i_addr,
    input  mem_access_pkg::word_t        i_wdata,
    input  mem_access_pkg::access_size_e i_size,
    input  logic                         i_unsigned,
    input  mem_ctrl_pkg::line_t          i_line,
    input  logic                         i_ctrl_busy,
    output logic                         o_req_rd,
    output logic                         o_req_wr,
    output mem_access_pkg::word_t        o_req_addr,
    output mem_access_pkg::word_t        o_req_wdata,
    output mem_access_pkg::byte_mask_t   o_req_mask,
    output mem_access_pkg::word_t        o_rdata,
    output logic                         o_busy
);

    logic                         w_accept;
    mem_access_pkg::word_t        w_aligned;
    mem_access_pkg::word_t        r_addr;
    mem_access_pkg::word_t        r_wdata;
    mem_access_pkg::access_size_e r_size;
    logic [3:0]                   r_ld_ofs;
    mem_access_pkg::access_size_e r_ld_size;
    logic                         r_ld_unsigned;
    mem_access_pkg::word_t        w_word;
    logic [7:0]                   w_byte;
    logic [15:0]                  w_half;

    assign w_accept = (i_rd_en || i_wr_en) && !o_busy;
    assign o_busy   = o_req_rd || o_req_wr || i_ctrl_busy;

    // halfwords and words are forced to their natural alignment
    always_comb begin
        case (i_size)
            mem_access_pkg::SIZE_BYTE: w_aligned = i_addr;
            mem_access_pkg::SIZE_HALF: w_aligned = {i_addr[31:1], 1'b0};
            default:                   w_aligned = {i_addr[31:2], 2'b00};
        endcase
    end

    // one-cycle request pulse, a store wins over a load
    always_ff @(posedge CLK) begin
        if (!i_rrst_x) begin
            o_req_rd <= 1'b0;
            o_req_wr <= 1'b0;
        end else begin
            o_req_rd <= w_accept && i_rd_en && !i_wr_en;
            o_req_wr <= w_accept && i_wr_en;
        end
    end

    // load fields only move on a load so o_rdata holds across stores
    always_ff @(posedge CLK) begin
        if (w_accept) begin
            r_addr  <= w_aligned;
            r_wdata <= i_wdata;
            r_size  <= i_size;
        end
        if (w_accept && !i_wr_en) begin
            r_ld_ofs      <= w_aligned[3:0];
            r_ld_size     <= i_size;
            r_ld_unsigned <= i_unsigned;
        end
    end

    assign o_req_addr = r_addr;

    // replicate store data into every lane of its size
    always_comb begin
        case (r_size)
            mem_access_pkg::SIZE_BYTE: begin
                o_req_wdata = {4{r_wdata[7:0]}};
                o_req_mask  = 4'b0001 << r_addr[1:0];
            end
            mem_access_pkg::SIZE_HALF: begin
                o_req_wdata = {2{r_wdata[15:0]}};
                o_req_mask  = 4'b0011 << {r_addr[1], 1'b0};
            end
            default: begin
                o_req_wdata = r_wdata;
                o_req_mask  = 4'b1111;
            end
        endcase
    end

    // word, then lane, out of the returned line
    assign w_word = i_line[{r_ld_ofs[3:2], 5'd0} +: 32];
    assign w_byte = w_word[{r_ld_ofs[1:0], 3'd0} +: 8];
    assign w_half = w_word[{r_ld_ofs[1], 4'd0} +: 16];

    always_comb begin
        case (r_ld_size)
            mem_access_pkg::SIZE_BYTE: o_rdata = {{24{w_byte[7] & ~r_ld_unsigned}}, w_byte};
            mem_access_pkg::SIZE_HALF: o_rdata = {{16{w_half[15] & ~r_ld_unsigned}}, w_half};
            default:                   o_rdata = w_word;
        endcase
    end

endmodule

/* design/mem_top.sv */
module mem_top (
    input  logic                         CLK,
    input  logic                         i_rrst_x,
    input  logic                         i_rd_en,
    input  logic                         i_wr_en,
    input  mem_access_pkg::word_t        i_addr,
    input  mem_access_pkg::word_t        i_wdata,
    input  mem_access_pkg::access_size_e i_size,
    input  logic                         i_unsigned,
    output mem_access_pkg::word_t        o_rdata,
    output logic                         o_busy
);

    logic                       w_req_rd;
    logic                       w_req_wr;
    logic                       w_ctrl_busy;
    mem_access_pkg::word_t      w_req_addr;
    mem_access_pkg::word_t      w_req_wdata;
    mem_access_pkg::byte_mask_t w_req_mask;
    mem_ctrl_pkg::line_t        w_line;

    // core side formatting
    mem_access_unit u_access (
        .CLK         (CLK),
        .i_rrst_x    (i_rrst_x),
        .i_rd_en     (i_rd_en),
        .i_wr_en     (i_wr_en),
        .i_addr      (i_addr),
        .i_wdata     (i_wdata),
        .i_size      (i_size),
        .i_unsigned  (i_unsigned),
        .i_line      (w_line),
        .i_ctrl_busy (w_ctrl_busy),
        .o_req_rd    (w_req_rd),
        .o_req_wr    (w_req_wr),
        .o_req_addr  (w_req_addr),
        .o_req_wdata (w_req_wdata),
        .o_req_mask  (w_req_mask),
        .o_rdata     (o_rdata),
        .o_busy      (o_busy)
    );

    // cache and backing store
    cache_ctrl u_ctrl (
        .CLK         (CLK),
        .i_rrst_x    (i_rrst_x),
        .i_req_rd    (w_req_rd),
        .i_req_wr    (w_req_wr),
        .i_req_addr  (w_req_addr),
        .i_req_wdata (w_req_wdata),
        .i_req_mask  (w_req_mask),
        .o_line      (w_line),
        .o_busy      (w_ctrl_busy)
    );

endmodule

/* sim/tb_mem_top.sv */
`include "mem_params.svh"

module tb_mem_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int OP_RD = 0;
    localparam int OP_WR = 1;
    // word store, then a second store held high while busy
    localparam int OP_STRAY = 2;
    localparam int MEM_BYTES = `MEM_LINES * `LINE_BYTES;
    localparam int WAIT_LIMIT = 4 * `MEM_LATENCY + 20;
    localparam int RAND_OPS = 200;
    // random phase stays in one alias window, so a line never carries two tags
    localparam logic [31:0] ALIAS_BASE = 32'h0001_0000;
    localparam mem_access_pkg::access_size_e SZ_B = mem_access_pkg::SIZE_BYTE;
    localparam mem_access_pkg::access_size_e SZ_H = mem_access_pkg::SIZE_HALF;
    localparam mem_access_pkg::access_size_e SZ_W = mem_access_pkg::SIZE_WORD;

    typedef struct {
        int                           op;
        logic [31:0]                  addr;
        logic [31:0]                  data;
        mem_access_pkg::access_size_e size;
        logic                         uns;
        logic [31:0]                  exp;
    } row_t;

    logic                         CLK;
    logic                         i_rrst_x;
    logic                         i_rd_en;
    logic                         i_wr_en;
    mem_access_pkg::word_t        i_addr;
    mem_access_pkg::word_t        i_wdata;
    mem_access_pkg::access_size_e i_size;
    logic                         i_unsigned;
    mem_access_pkg::word_t        o_rdata;
    logic                         o_busy;

    row_t        table_q[$];
    row_t        row;
    logic [7:0]  ref_mem [MEM_BYTES];
    logic [31:0] seed;
    logic [31:0] r_addr;
    logic [31:0] r_data;
    logic [31:0] r_exp;
    int          r_op;
    int          errors;
    int          tests;
    int          passed;
    int          e0;
    bit          hung;
    mem_access_pkg::access_size_e r_size;
    logic                         r_uns;

    mem_top DUT (
        .CLK        (CLK),
        .i_rrst_x   (i_rrst_x),
        .i_rd_en    (i_rd_en),
        .i_wr_en    (i_wr_en),
        .i_addr     (i_addr),
        .i_wdata    (i_wdata),
        .i_size     (i_size),
        .i_unsigned (i_unsigned),
        .o_rdata    (o_rdata),
        .o_busy     (o_busy)
    );

    always #5 CLK = ~CLK;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // byte offset inside the 1 KiB model after natural alignment
    function automatic int align_index(input logic [31:0] addr,
                                       input mem_access_pkg::access_size_e size);
        logic [31:0] a;
        a = addr;
        if (size == SZ_H) a[0] = 1'b0;
        if (size == SZ_W) a[1:0] = 2'b00;
        return int'(a % MEM_BYTES);
    endfunction

    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input mem_access_pkg::access_size_e size,
                                                  input logic uns);
        int          a;
        logic [31:0] v;
        a = align_index(addr, size);
        if (size == SZ_B) begin
            v = {24'd0, ref_mem[a]};
            if (!uns && v[7]) v[31:8] = 24'hFF_FFFF;
        end else if (size == SZ_H) begin
            v = {16'd0, ref_mem[a+1], ref_mem[a]};
            if (!uns && v[15]) v[31:16] = 16'hFFFF;
        end else begin
            v = {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
        end
        return v;
    endfunction

    function automatic void record_store(input logic [31:0] addr, input logic [31:0] data,
                                         input mem_access_pkg::access_size_e size);
        int a;
        int n;
        a = align_index(addr, size);
        n = (size == SZ_B) ? 1 : (size == SZ_H) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[a+i] = data[i*8 +: 8];
        end
    endfunction

    task automatic add_row(input int op, input logic [31:0] addr, input logic [31:0] data,
                           input mem_access_pkg::access_size_e size, input logic uns,
                           input logic [31:0] exp);
        row_t r;
        r.op   = op;
        r.addr = addr;
        r.data = data;
        r.size = size;
        r.uns  = uns;
        r.exp  = exp;
        table_q.push_back(r);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("FAILED at %0d ns: %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // busy is sampled on the falling edge, away from the DUT's updates
    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge CLK);
        while (o_busy && n < WAIT_LIMIT) begin
            @(negedge CLK);
            n++;
        end
        if (o_busy) begin
            $display("timeout: o_busy stayed high for %0d cycles", WAIT_LIMIT);
            hung = 1'b1;
            errors++;
        end
    endtask

    task automatic run_access(input int op, input logic [31:0] addr, input logic [31:0] data,
                              input mem_access_pkg::access_size_e size, input logic uns);
        @(posedge CLK);
        i_rd_en    <= (op == OP_RD);
        i_wr_en    <= (op != OP_RD);
        i_addr     <= addr;
        i_wdata    <= data;
        i_size     <= size;
        i_unsigned <= uns;
        @(posedge CLK);
        i_rd_en <= 1'b0;
        i_wr_en <= 1'b0;
        // busy rises right after the accepting edge
        @(negedge CLK);
        check_value("o_busy", 32'd1, {31'd0, o_busy});
        if (op == OP_STRAY) begin
            // held through the store's memory latency, every edge must drop it
            @(posedge CLK);
            i_wr_en <= 1'b1;
            i_addr  <= addr ^ 32'h10;
            i_wdata <= ~data;
            repeat (`MEM_LATENCY) @(posedge CLK);
            i_wr_en <= 1'b0;
        end
        wait_idle();
    endtask

    initial begin
        CLK        = 1'b0;
        i_rrst_x   = 1'b0;
        i_rd_en    = 1'b0;
        i_wr_en    = 1'b0;
        i_addr     = '0;
        i_wdata    = '0;
        i_size     = SZ_W;
        i_unsigned = 1'b0;
        errors     = 0;
        tests      = 0;
        passed     = 0;
        hung       = 1'b0;
        foreach (ref_mem[i]) ref_mem[i] = 8'h00;

        repeat (4) @(posedge CLK);
        i_rrst_x <= 1'b1;
        @(negedge CLK);
        check_value("o_busy", 32'd0, {31'd0, o_busy});

        // reset contents
        add_row(OP_RD, 32'h000, 32'h0, SZ_W, 1'b0, 32'h0000_0000);
        add_row(OP_RD, 32'h3FC, 32'h0, SZ_W, 1'b0, 32'h0000_0000);
        add_row(OP_RD, 32'h3FF, 32'h0, SZ_B, 1'b0, 32'h0000_0000);
        // word store, then every lane with both extensions
        add_row(OP_WR, 32'h100, 32'h8A7B_C6F5, SZ_W, 1'b0, 32'h0);
        add_row(OP_RD, 32'h100, 32'h0, SZ_W, 1'b0, 32'h8A7B_C6F5);
        add_row(OP_RD, 32'h100, 32'h0, SZ_B, 1'b0, 32'hFFFF_FFF5);
        add_row(OP_RD, 32'h100, 32'h0, SZ_B, 1'b1, 32'h0000_00F5);
        add_row(OP_RD, 32'h101, 32'h0, SZ_B, 1'b1, 32'h0000_00C6);
        add_row(OP_RD, 32'h102, 32'h0, SZ_B, 1'b0, 32'h0000_007B);
        add_row(OP_RD, 32'h103, 32'h0, SZ_B, 1'b0, 32'hFFFF_FF8A);
        add_row(OP_RD, 32'h100, 32'h0, SZ_H, 1'b0, 32'hFFFF_C6F5);
        add_row(OP_RD, 32'h102, 32'h0, SZ_H, 1'b1, 32'h0000_8A7B);
        add_row(OP_RD, 32'h103, 32'h0, SZ_H, 1'b0, 32'hFFFF_8A7B);
        add_row(OP_RD, 32'h102, 32'h0, SZ_W, 1'b0, 32'h8A7B_C6F5);
        // partial stores merge into one word
        add_row(OP_WR, 32'h140, 32'h1122_3344, SZ_W, 1'b0, 32'h0);
        add_row(OP_WR, 32'h141, 32'h0000_00AB, SZ_B, 1'b0, 32'h0);
        add_row(OP_WR, 32'h142, 32'h0000_CDEF, SZ_H, 1'b0, 32'h0);
        add_row(OP_RD, 32'h140, 32'h0, SZ_W, 1'b0, 32'hCDEF_AB44);
        add_row(OP_RD, 32'h143, 32'h0, SZ_B, 1'b1, 32'h0000_00CD);
        // repeat read, invalidate on write hit, index conflict, wrapped alias
        add_row(OP_RD, 32'h200, 32'h0, SZ_W, 1'b0, 32'h0000_0000);
        add_row(OP_RD, 32'h200, 32'h0, SZ_W, 1'b0, 32'h0000_0000);
        add_row(OP_WR, 32'h204, 32'hDEAD_BEEF, SZ_W, 1'b0, 32'h0);
        add_row(OP_RD, 32'h204, 32'h0, SZ_W, 1'b0, 32'hDEAD_BEEF);
        add_row(OP_RD, 32'h200, 32'h0, SZ_W, 1'b0, 32'h0000_0000);
        add_row(OP_WR, 32'h280, 32'h0BAD_F00D, SZ_W, 1'b0, 32'h0);
        add_row(OP_RD, 32'h280, 32'h0, SZ_W, 1'b0, 32'h0BAD_F00D);
        add_row(OP_RD, 32'h204, 32'h0, SZ_W, 1'b0, 32'hDEAD_BEEF);
        add_row(OP_RD, 32'h280, 32'h0, SZ_W, 1'b0, 32'h0BAD_F00D);
        add_row(OP_RD, 32'h604, 32'h0, SZ_W, 1'b0, 32'hDEAD_BEEF);
        // strobe while busy is ignored
        add_row(OP_STRAY, 32'h300, 32'h1357_9BDF, SZ_W, 1'b0, 32'h0);
        add_row(OP_RD, 32'h300, 32'h0, SZ_W, 1'b0, 32'h1357_9BDF);
        add_row(OP_RD, 32'h310, 32'h0, SZ_W, 1'b0, 32'h0000_0000);

        for (int i = 0; i < table_q.size() && !hung; i++) begin
            row = table_q[i];
            e0  = errors;
            run_access(row.op, row.addr, row.data, row.size, row.uns);
            if (row.op == OP_RD) begin
                check_value("o_rdata", row.exp, o_rdata);
            end else begin
                record_store(row.addr, row.data, row.size);
            end
            tests++;
            if (errors == e0) passed++;
            $display("test %0d %s addr %h: %s", i, (row.op == OP_RD) ? "load" : "store",
                     row.addr, (errors == e0) ? "pass" : "fail");
        end

        if (!hung) begin
            e0   = errors;
            seed = 32'ha4501228;
            for (int k = 0; k < RAND_OPS && !hung; k++) begin
                seed   = lcg_next(seed);
                r_op   = seed[31] ? OP_WR : OP_RD;
                r_size = (seed[30:29] == 2'd3) ? SZ_W
                                               : mem_access_pkg::access_size_e'(seed[30:29]);
                r_uns  = seed[28];
                r_addr = ALIAS_BASE | {22'd0, seed[25:16]};
                seed   = lcg_next(seed);
                r_data = seed;
                r_exp  = expected_load(r_addr, r_size, r_uns);
                run_access(r_op, r_addr, r_data, r_size, r_uns);
                if (r_op == OP_RD) begin
                    check_value("o_rdata", r_exp, o_rdata);
                end else begin
                    record_store(r_addr, r_data, r_size);
                end
            end
            tests++;
            if (errors == e0) passed++;
            $display("test random (%0d accesses): %s", RAND_OPS, (errors == e0) ? "pass" : "fail");
        end

        $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
                 tests, passed, tests - passed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+design
design/mem_access_pkg.sv
design/mem_ctrl_pkg.sv
design/line_cache.sv
design/backing_mem.sv
design/cache_ctrl.sv
design/mem_access_unit.sv
design/mem_top.sv
sim/tb_mem_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the pass line shows up
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_mem_top -o tb_mem_top \
    && ./obj_dir/tb_mem_top | tee /dev/stderr | grep -q "All tests passed" \
    && echo "simulation PASSED" \
    || { echo "simulation FAILED"; exit 1; }
